// File: include/id_macros.svh
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// data path width
`define WORD_W 32

// register address width, 32 architectural registers
`define REG_AW 5

// instruction queue entries, also the fetch credits granted after reset
`define IQ_DEPTH 4

// issue slots the execute stage can absorb
`define EX_CREDITS 2

`endif

// File: hdl/isa_pkg.sv
`include "id_macros.svh"

package isa_pkg;

	// primary opcode, instruction bits 31:26
	typedef enum logic [5:0] {
		opc_special = 6'b000000,
		opc_j       = 6'b000010,
		opc_jal     = 6'b000011,
		opc_addiu   = 6'b001001,
		opc_slti    = 6'b001010,
		opc_andi    = 6'b001100,
		opc_ori     = 6'b001101,
		opc_xori    = 6'b001110,
		opc_lw      = 6'b100011
	} opcode_e;

	// function field of R-type instructions
	typedef enum logic [5:0] {
		fn_addu = 6'b100001,
		fn_subu = 6'b100011,
		fn_and  = 6'b100100,
		fn_or   = 6'b100101,
		fn_xor  = 6'b100110,
		fn_slt  = 6'b101010
	} funct_e;

	// decoded operation handed to execute
	typedef enum logic [3:0] {
		op_invalid = 4'd0,
		op_addiu,
		op_slti,
		op_lw,
		op_andi,
		op_ori,
		op_xori,
		op_j,
		op_jal,
		op_addu,
		op_subu,
		op_and,
		op_or,
		op_xor,
		op_slt
	} oper_e;

	typedef struct packed {
		opcode_e            opcode;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] rd;
		logic [4:0]         shamt;
		funct_e             funct;
	} inst_r_t;

	typedef struct packed {
		opcode_e            opcode;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [15:0]        imm;
	} inst_i_t;

	// the jump target index is shifted left two bits by the branch unit
	typedef struct packed {
		opcode_e     opcode;
		logic [25:0] index;
	} inst_j_t;

	// one instruction word, viewed in whichever format the opcode selects
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
		inst_j_t j;
	} inst_u;

endpackage

// File: hdl/pipe_pkg.sv
`include "id_macros.svh"

package pipe_pkg;

	// what fetch pushes into the instruction queue
	typedef struct packed {
		logic [`WORD_W-1:0] pc;
		isa_pkg::inst_u     inst;
	} fetch_pkt_t;

	// register write request, used both for forwarding and writeback
	typedef struct packed {
		logic               we;
		logic [`REG_AW-1:0] waddr;
		logic [`WORD_W-1:0] wdata;
	} reg_wr_t;

	// memory access of a stage, a load is ce without we
	typedef struct packed {
		logic ce;
		logic we;
	} mem_req_t;

	// decoded bundle from decode to execute
	typedef struct packed {
		logic [`WORD_W-1:0] pc;
		isa_pkg::oper_e     op;
		logic [`WORD_W-1:0] op1;
		logic [`WORD_W-1:0] op2;
		logic [`WORD_W-1:0] imm;
		logic               we;
		logic [`REG_AW-1:0] waddr;
	} id_ex_t;

endpackage

// File: hdl/inst_queue.sv
`timescale 1ns/1ps
`include "id_macros.svh"

module inst_queue (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 push_i,
	input  pipe_pkg::fetch_pkt_t pkt_i,
	input  logic                 pop_i,
	output pipe_pkg::fetch_pkt_t head_o,
	output logic                 not_empty_o,
	output logic                 credit_o
);

	localparam int PTR_W = $clog2(`IQ_DEPTH);
	localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

	pipe_pkg::fetch_pkt_t mem_q [`IQ_DEPTH];
	logic [PTR_W-1:0]     wr_ptr_q;
	logic [PTR_W-1:0]     rd_ptr_q;
	logic [CNT_W-1:0]     count_q;

	always_ff @(posedge clk_i) begin
		if (push_i) begin
			mem_q[wr_ptr_q] <= pkt_i;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			credit_o <= 1'b0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= (wr_ptr_q == PTR_W'(`IQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (pop_i) begin
				rd_ptr_q <= (rd_ptr_q == PTR_W'(`IQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
			// every freed slot goes back to fetch as one credit
			credit_o <= pop_i;
		end
	end

	assign head_o      = mem_q[rd_ptr_q];
	assign not_empty_o = (count_q != '0);

	// fetch only pushes with a credit in hand, so a full queue never sees a push
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		push_i |-> count_q < CNT_W'(`IQ_DEPTH))
		else $error("push into a full instruction queue");

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`include "id_macros.svh"

module reg_file (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic [`REG_AW-1:0]   raddr1_i,
	input  logic [`REG_AW-1:0]   raddr2_i,
	output logic [`WORD_W-1:0]   rdata1_o,
	output logic [`WORD_W-1:0]   rdata2_o,
	input  pipe_pkg::reg_wr_t    wr_i
);

	localparam int NREG = 1 << `REG_AW;

	// $0 has no storage
	logic [`WORD_W-1:0] regs_q [1:NREG-1];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 1; i < NREG; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_i.we && wr_i.waddr != '0) begin
			regs_q[wr_i.waddr] <= wr_i.wdata;
		end
	end

	// writeback in the same cycle wins over the stored value
	always_comb begin
		if (raddr1_i == '0) begin
			rdata1_o = '0;
		end else if (wr_i.we && wr_i.waddr == raddr1_i) begin
			rdata1_o = wr_i.wdata;
		end else begin
			rdata1_o = regs_q[raddr1_i];
		end
	end

	always_comb begin
		if (raddr2_i == '0) begin
			rdata2_o = '0;
		end else if (wr_i.we && wr_i.waddr == raddr2_i) begin
			rdata2_o = wr_i.wdata;
		end else begin
			rdata2_o = regs_q[raddr2_i];
		end
	end

endmodule

// File: hdl/id_opcode_decode.sv
`timescale 1ns/1ps

module id_opcode_decode (
	input  isa_pkg::inst_u inst_i,
	output isa_pkg::oper_e op_i_o,
	output isa_pkg::oper_e op_j_o,
	output isa_pkg::oper_e op_r_o,
	output logic           read_rt_o,
	output logic           unsigned_imm_o
);

	// immediate format
	always_comb begin
		op_i_o         = isa_pkg::op_invalid;
		unsigned_imm_o = 1'b0;
		// rt is a destination for every supported I-type, stores would read it
		read_rt_o      = 1'b0;
		case (inst_i.i.opcode)
			isa_pkg::opc_addiu: op_i_o = isa_pkg::op_addiu;
			isa_pkg::opc_slti:  op_i_o = isa_pkg::op_slti;
			isa_pkg::opc_lw:    op_i_o = isa_pkg::op_lw;
			isa_pkg::opc_andi: begin
				op_i_o         = isa_pkg::op_andi;
				unsigned_imm_o = 1'b1;
			end
			isa_pkg::opc_ori: begin
				op_i_o         = isa_pkg::op_ori;
				unsigned_imm_o = 1'b1;
			end
			isa_pkg::opc_xori: begin
				op_i_o         = isa_pkg::op_xori;
				unsigned_imm_o = 1'b1;
			end
			default: op_i_o = isa_pkg::op_invalid;
		endcase
	end

	// jump format
	always_comb begin
		case (inst_i.j.opcode)
			isa_pkg::opc_j:   op_j_o = isa_pkg::op_j;
			isa_pkg::opc_jal: op_j_o = isa_pkg::op_jal;
			default:          op_j_o = isa_pkg::op_invalid;
		endcase
	end

	// register format, opcode zero and the operation in funct
	always_comb begin
		op_r_o = isa_pkg::op_invalid;
		if (inst_i.r.opcode == isa_pkg::opc_special) begin
			case (inst_i.r.funct)
				isa_pkg::fn_addu: op_r_o = isa_pkg::op_addu;
				isa_pkg::fn_subu: op_r_o = isa_pkg::op_subu;
				isa_pkg::fn_and:  op_r_o = isa_pkg::op_and;
				isa_pkg::fn_or:   op_r_o = isa_pkg::op_or;
				isa_pkg::fn_xor:  op_r_o = isa_pkg::op_xor;
				isa_pkg::fn_slt:  op_r_o = isa_pkg::op_slt;
				default:          op_r_o = isa_pkg::op_invalid;
			endcase
		end
	end

endmodule

// File: hdl/cpu_id.sv
`timescale 1ns/1ps
`include "id_macros.svh"

module cpu_id (
	input  pipe_pkg::fetch_pkt_t head_i,
	input  logic                 head_valid_i,
	input  logic [`WORD_W-1:0]   reg1_i,
	input  logic [`WORD_W-1:0]   reg2_i,
	input  pipe_pkg::reg_wr_t    ex_wr_i,
	input  pipe_pkg::reg_wr_t    mem_wr_i,
	input  pipe_pkg::mem_req_t   ex_mem_req_i,
	output logic [`REG_AW-1:0]   raddr1_o,
	output logic [`REG_AW-1:0]   raddr2_o,
	output pipe_pkg::id_ex_t     dec_o,
	output logic                 stall_o
);

	isa_pkg::inst_u     inst;
	isa_pkg::oper_e     op_i;
	isa_pkg::oper_e     op_j;
	isa_pkg::oper_e     op_r;
	logic               read_rt;
	logic               unsigned_imm;
	logic [`WORD_W-1:0] imm_zext;
	logic [`WORD_W-1:0] imm_sext;
	logic               ex_load;

	// newest producer first: execute, then memory, then the register file
	function automatic logic [`WORD_W-1:0] forward(
		input logic [`REG_AW-1:0] addr,
		input logic [`WORD_W-1:0] rf_data,
		input pipe_pkg::reg_wr_t  ex_wr,
		input pipe_pkg::reg_wr_t  mem_wr
	);
		if (addr == '0) begin
			return '0;
		end else if (ex_wr.we && ex_wr.waddr == addr) begin
			return ex_wr.wdata;
		end else if (mem_wr.we && mem_wr.waddr == addr) begin
			return mem_wr.wdata;
		end
		return rf_data;
	endfunction

	assign inst     = head_i.inst;
	assign imm_zext = {{(`WORD_W - 16){1'b0}}, inst.i.imm};
	assign imm_sext = {{(`WORD_W - 16){inst.i.imm[15]}}, inst.i.imm};

	id_opcode_decode u_opcode_decode (
		.inst_i         (inst),
		.op_i_o         (op_i),
		.op_j_o         (op_j),
		.op_r_o         (op_r),
		.read_rt_o      (read_rt),
		.unsigned_imm_o (unsigned_imm)
	);

	always_comb begin
		dec_o.pc = head_i.pc;
		if (op_i != isa_pkg::op_invalid) begin
			dec_o.op    = op_i;
			raddr1_o    = inst.i.rs;
			raddr2_o    = read_rt ? inst.i.rt : '0;
			dec_o.imm   = unsigned_imm ? imm_zext : imm_sext;
			dec_o.we    = 1'b1;
			dec_o.waddr = inst.i.rt;
		end else if (op_j != isa_pkg::op_invalid) begin
			dec_o.op    = op_j;
			raddr1_o    = '0;
			raddr2_o    = '0;
			dec_o.imm   = '0;
			// JAL links into $31, plain J writes nothing
			dec_o.we    = (op_j == isa_pkg::op_jal);
			dec_o.waddr = '1;
		end else if (op_r != isa_pkg::op_invalid) begin
			dec_o.op    = op_r;
			raddr1_o    = inst.r.rs;
			raddr2_o    = inst.r.rt;
			dec_o.imm   = '0;
			dec_o.we    = 1'b1;
			dec_o.waddr = inst.r.rd;
		end else begin
			dec_o.op    = isa_pkg::op_invalid;
			raddr1_o    = '0;
			raddr2_o    = '0;
			dec_o.imm   = '0;
			dec_o.we    = 1'b0;
			dec_o.waddr = '0;
		end
		dec_o.op1 = forward(raddr1_o, reg1_i, ex_wr_i, mem_wr_i);
		dec_o.op2 = forward(raddr2_o, reg2_i, ex_wr_i, mem_wr_i);
	end

	// load result is not ready until memory, so a dependent head must wait
	assign ex_load = ex_mem_req_i.ce && !ex_mem_req_i.we;
	assign stall_o = head_valid_i && ex_load &&
		((raddr1_o != '0 && ex_wr_i.waddr == raddr1_o) ||
		 (raddr2_o != '0 && ex_wr_i.waddr == raddr2_o));

endmodule

// File: hdl/id_issue_port.sv
`timescale 1ns/1ps
`include "id_macros.svh"

module id_issue_port (
	input  logic             clk_i,
	input  logic             arst_n_i,
	input  pipe_pkg::id_ex_t dec_i,
	input  logic             ready_i,
	input  logic             stall_i,
	input  logic             credit_i,
	output logic             pop_o,
	output logic             ex_valid_o,
	output pipe_pkg::id_ex_t ex_pkt_o
);

	localparam int CRED_W = $clog2(`EX_CREDITS + 1);

	logic [CRED_W-1:0] credit_q;

	// take the head only when execute has room for it
	assign pop_o = ready_i && !stall_i && (credit_q != '0);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			credit_q   <= CRED_W'(`EX_CREDITS);
			ex_valid_o <= 1'b0;
		end else begin
			ex_valid_o <= pop_o;
			case ({pop_o, credit_i})
				2'b10:   credit_q <= credit_q - 1'b1;
				2'b01:   credit_q <= credit_q + 1'b1;
				default: credit_q <= credit_q;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (pop_o) begin
			ex_pkt_o <= dec_i;
		end
	end

	// execute returns no more credits than it was handed
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		credit_q <= CRED_W'(`EX_CREDITS))
		else $error("execute credit count above %0d", `EX_CREDITS);

endmodule

// File: hdl/id_stage_top.sv
`timescale 1ns/1ps
`include "id_macros.svh"

module id_stage_top (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 fetch_valid_i,
	input  pipe_pkg::fetch_pkt_t fetch_pkt_i,
	output logic                 fetch_credit_o,
	input  pipe_pkg::reg_wr_t    ex_wr_i,
	input  pipe_pkg::reg_wr_t    mem_wr_i,
	input  pipe_pkg::reg_wr_t    wb_wr_i,
	input  pipe_pkg::mem_req_t   ex_mem_req_i,
	output logic                 ex_valid_o,
	output pipe_pkg::id_ex_t     ex_pkt_o,
	input  logic                 ex_credit_i
);

	pipe_pkg::fetch_pkt_t head;
	logic                 head_valid;
	logic                 pop;
	logic                 stall;
	logic [`REG_AW-1:0]   raddr1;
	logic [`REG_AW-1:0]   raddr2;
	logic [`WORD_W-1:0]   rdata1;
	logic [`WORD_W-1:0]   rdata2;
	pipe_pkg::id_ex_t     dec;

	inst_queue u_inst_queue (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.push_i      (fetch_valid_i),
		.pkt_i       (fetch_pkt_i),
		.pop_i       (pop),
		.head_o      (head),
		.not_empty_o (head_valid),
		.credit_o    (fetch_credit_o)
	);

	// writeback port also feeds the bypass inside the register file
	reg_file u_reg_file (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.wr_i     (wb_wr_i)
	);

	cpu_id u_cpu_id (
		.head_i       (head),
		.head_valid_i (head_valid),
		.reg1_i       (rdata1),
		.reg2_i       (rdata2),
		.ex_wr_i      (ex_wr_i),
		.mem_wr_i     (mem_wr_i),
		.ex_mem_req_i (ex_mem_req_i),
		.raddr1_o     (raddr1),
		.raddr2_o     (raddr2),
		.dec_o        (dec),
		.stall_o      (stall)
	);

	id_issue_port u_issue_port (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.dec_i      (dec),
		.ready_i    (head_valid),
		.stall_i    (stall),
		.credit_i   (ex_credit_i),
		.pop_o      (pop),
		.ex_valid_o (ex_valid_o),
		.ex_pkt_o   (ex_pkt_o)
	);

endmodule

// File: verif/tb_id_stage.sv
`timescale 1ns/1ps
`include "id_macros.svh"

module tb_id_stage;

	localparam int NPKT = 400;
	// about five cycles per packet
	localparam int LIMIT = 2000;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic                 clk_i = 1'b0;
	logic                 arst_n_i;
	logic                 fetch_valid_i;
	pipe_pkg::fetch_pkt_t fetch_pkt_i;
	logic                 fetch_credit_o;
	pipe_pkg::reg_wr_t    ex_wr_i;
	pipe_pkg::reg_wr_t    mem_wr_i;
	pipe_pkg::reg_wr_t    wb_wr_i;
	pipe_pkg::mem_req_t   ex_mem_req_i;
	logic                 ex_valid_o;
	pipe_pkg::id_ex_t     ex_pkt_o;
	logic                 ex_credit_i;

	logic [31:0]          lfsr = 32'h3fe6c306;
	logic [`WORD_W-1:0]   shadow [32];
	pipe_pkg::fetch_pkt_t model_q [$];
	logic                 exp_valid_q = 1'b0;
	pipe_pkg::id_ex_t     exp_pkt_q;
	logic [`WORD_W-1:0]   next_pc = '0;
	int                   model_cred = `EX_CREDITS;
	int                   fetch_cred = `IQ_DEPTH;
	int                   held = 0;
	int                   sent = 0;
	int                   issued_seen = 0;
	int                   credits_back = 0;
	int                   cycles = 0;
	int                   val_err = 0;
	int                   other_err = 0;

	always #20 clk_i = ~clk_i;

	id_stage_top u_dut (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.fetch_valid_i  (fetch_valid_i),
		.fetch_pkt_i    (fetch_pkt_i),
		.fetch_credit_o (fetch_credit_o),
		.ex_wr_i        (ex_wr_i),
		.mem_wr_i       (mem_wr_i),
		.wb_wr_i        (wb_wr_i),
		.ex_mem_req_i   (ex_mem_req_i),
		.ex_valid_o     (ex_valid_o),
		.ex_pkt_o       (ex_pkt_o),
		.ex_credit_i    (ex_credit_i)
	);

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
		end
		return v;
	endfunction

	// registers drawn from $0..$7 so forwarding hits are frequent
	function automatic logic [31:0] make_inst();
		logic [3:0]  sel;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		sel = 4'(rand_bits(4));
		rs  = 5'(rand_bits(3));
		rt  = 5'(rand_bits(3));
		rd  = 5'(rand_bits(3));
		imm = 16'(rand_bits(16));
		case (sel)
			4'd0:    return {isa_pkg::opc_addiu, rs, rt, imm};
			4'd1:    return {isa_pkg::opc_slti, rs, rt, imm};
			4'd2:    return {isa_pkg::opc_lw, rs, rt, imm};
			4'd3:    return {isa_pkg::opc_andi, rs, rt, imm};
			4'd4:    return {isa_pkg::opc_ori, rs, rt, imm};
			4'd5:    return {isa_pkg::opc_xori, rs, rt, imm};
			4'd6:    return {isa_pkg::opc_j, rs, rt, imm};
			4'd7:    return {isa_pkg::opc_jal, rs, rt, imm};
			4'd8:    return {isa_pkg::opc_special, rs, rt, rd, 5'd0, isa_pkg::fn_addu};
			4'd9:    return {isa_pkg::opc_special, rs, rt, rd, 5'd0, isa_pkg::fn_subu};
			4'd10:   return {isa_pkg::opc_special, rs, rt, rd, 5'd0, isa_pkg::fn_and};
			4'd11:   return {isa_pkg::opc_special, rs, rt, rd, 5'd0, isa_pkg::fn_or};
			4'd12:   return {isa_pkg::opc_special, rs, rt, rd, 5'd0, isa_pkg::fn_xor};
			4'd13:   return {isa_pkg::opc_special, rs, rt, rd, 5'd0, isa_pkg::fn_slt};
			// unknown funct, then unknown opcode
			4'd14:   return {isa_pkg::opc_special, rs, rt, rd, 5'd0, 6'h3f};
			default: return {6'h3f, rs, rt, imm};
		endcase
	endfunction

	// ex, then mem, then writeback, then the stored value
	function automatic logic [`WORD_W-1:0] operand_value(input logic [4:0] a);
		if (a == '0) begin
			return '0;
		end else if (ex_wr_i.we && ex_wr_i.waddr == a) begin
			return ex_wr_i.wdata;
		end else if (mem_wr_i.we && mem_wr_i.waddr == a) begin
			return mem_wr_i.wdata;
		end else if (wb_wr_i.we && wb_wr_i.waddr == a) begin
			return wb_wr_i.wdata;
		end
		return shadow[a];
	endfunction

	function automatic void decode_expect(input pipe_pkg::fetch_pkt_t pkt,
		output pipe_pkg::id_ex_t exp, output logic [4:0] src1, output logic [4:0] src2);
		logic [31:0] w;
		logic [5:0]  opc;
		logic        zext;
		w    = pkt.inst;
		opc  = w[31:26];
		exp  = '0;
		src1 = '0;
		src2 = '0;
		exp.pc = pkt.pc;
		exp.op = isa_pkg::op_invalid;
		zext = (opc == isa_pkg::opc_andi || opc == isa_pkg::opc_ori ||
			opc == isa_pkg::opc_xori);
		case (opc)
			isa_pkg::opc_addiu: exp.op = isa_pkg::op_addiu;
			isa_pkg::opc_slti:  exp.op = isa_pkg::op_slti;
			isa_pkg::opc_lw:    exp.op = isa_pkg::op_lw;
			isa_pkg::opc_andi:  exp.op = isa_pkg::op_andi;
			isa_pkg::opc_ori:   exp.op = isa_pkg::op_ori;
			isa_pkg::opc_xori:  exp.op = isa_pkg::op_xori;
			isa_pkg::opc_j:     exp.op = isa_pkg::op_j;
			isa_pkg::opc_jal:   exp.op = isa_pkg::op_jal;
			isa_pkg::opc_special: begin
				case (w[5:0])
					isa_pkg::fn_addu: exp.op = isa_pkg::op_addu;
					isa_pkg::fn_subu: exp.op = isa_pkg::op_subu;
					isa_pkg::fn_and:  exp.op = isa_pkg::op_and;
					isa_pkg::fn_or:   exp.op = isa_pkg::op_or;
					isa_pkg::fn_xor:  exp.op = isa_pkg::op_xor;
					isa_pkg::fn_slt:  exp.op = isa_pkg::op_slt;
					default:          exp.op = isa_pkg::op_invalid;
				endcase
			end
			default: exp.op = isa_pkg::op_invalid;
		endcase
		if (opc == isa_pkg::opc_j || opc == isa_pkg::opc_jal) begin
			exp.we    = (opc == isa_pkg::opc_jal);
			exp.waddr = 5'd31;
		end else if (exp.op != isa_pkg::op_invalid && opc == isa_pkg::opc_special) begin
			src1      = w[25:21];
			src2      = w[20:16];
			exp.we    = 1'b1;
			exp.waddr = w[15:11];
		end else if (exp.op != isa_pkg::op_invalid) begin
			src1      = w[25:21];
			exp.we    = 1'b1;
			exp.waddr = w[20:16];
			exp.imm   = zext ? {16'h0000, w[15:0]} : {{16{w[15]}}, w[15:0]};
		end
		exp.op1 = operand_value(src1);
		exp.op2 = operand_value(src2);
	endfunction

	// runs at the rising edge, with the inputs the DUT samples there
	task automatic update_model();
		pipe_pkg::id_ex_t exp;
		logic [4:0]       s1;
		logic [4:0]       s2;
		logic             load;
		logic             stall;
		logic             pop;
		pop = 1'b0;
		if (model_q.size() != 0) begin
			decode_expect(model_q[0], exp, s1, s2);
			load  = ex_mem_req_i.ce && !ex_mem_req_i.we;
			stall = load && ((s1 != '0 && ex_wr_i.waddr == s1) ||
				(s2 != '0 && ex_wr_i.waddr == s2));
			pop   = !stall && model_cred > 0;
			if (pop) begin
				exp_pkt_q = exp;
				model_q.delete(0);
				model_cred--;
			end
		end
		exp_valid_q = pop;
		if (ex_credit_i) begin
			model_cred++;
		end
		if (fetch_valid_i) begin
			model_q.push_back(fetch_pkt_i);
		end
		if (wb_wr_i.we && wb_wr_i.waddr != '0) begin
			shadow[wb_wr_i.waddr] = wb_wr_i.wdata;
		end
	endtask

	task automatic drive_inputs();
		if (ex_valid_o) begin
			issued_seen++;
			held++;
		end
		if (fetch_credit_o) begin
			fetch_cred++;
			credits_back++;
		end
		if (fetch_cred > 0 && sent < NPKT && rand_bits(2) != 0) begin
			fetch_valid_i    = 1'b1;
			fetch_pkt_i.pc   = next_pc;
			fetch_pkt_i.inst = make_inst();
			next_pc          = next_pc + 32'd4;
			sent++;
			fetch_cred--;
		end else begin
			fetch_valid_i = 1'b0;
		end
		ex_wr_i      = {1'(rand_bits(1)), 5'(rand_bits(3)), rand_bits(32)};
		mem_wr_i     = {1'(rand_bits(1)), 5'(rand_bits(3)), rand_bits(32)};
		wb_wr_i      = {1'(rand_bits(1)), 5'(rand_bits(3)), rand_bits(32)};
		ex_mem_req_i = 2'(rand_bits(2));
		// a load in execute always has a destination
		if (ex_mem_req_i.ce && !ex_mem_req_i.we) begin
			ex_wr_i.we = 1'b1;
		end
		// execute holds its credits back for a stretch every 64 cycles
		if ((cycles % 64) < 48 && held > 0 && rand_bits(2) != 0) begin
			ex_credit_i = 1'b1;
			held--;
		end else begin
			ex_credit_i = 1'b0;
		end
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		val_err++;
		$display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
	endtask

	a_reset: assert property (@(posedge clk_i) !arst_n_i |-> !ex_valid_o && !fetch_credit_o)
		else report_mismatch("ex_valid_o,fetch_credit_o in reset", 64'(0),
			64'({$sampled(ex_valid_o), $sampled(fetch_credit_o)}));

	a_issue: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ex_valid_o == exp_valid_q)
		else report_mismatch("ex_valid_o", 64'($sampled(exp_valid_q)), 64'($sampled(ex_valid_o)));

	// one fetch credit for every pop, in the same cycle as the issue
	a_fetch_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		fetch_credit_o == exp_valid_q)
		else report_mismatch("fetch_credit_o", 64'($sampled(exp_valid_q)),
			64'($sampled(fetch_credit_o)));

	a_order: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ex_valid_o && exp_valid_q |-> ex_pkt_o.pc == exp_pkt_q.pc)
		else report_mismatch("ex_pkt_o.pc", 64'($sampled(exp_pkt_q.pc)),
			64'($sampled(ex_pkt_o.pc)));

	a_op: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ex_valid_o && exp_valid_q |-> ex_pkt_o.op == exp_pkt_q.op)
		else report_mismatch("ex_pkt_o.op", 64'($sampled(exp_pkt_q.op)),
			64'($sampled(ex_pkt_o.op)));

	a_op1: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ex_valid_o && exp_valid_q |-> ex_pkt_o.op1 == exp_pkt_q.op1)
		else report_mismatch("ex_pkt_o.op1", 64'($sampled(exp_pkt_q.op1)),
			64'($sampled(ex_pkt_o.op1)));

	a_op2: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ex_valid_o && exp_valid_q |-> ex_pkt_o.op2 == exp_pkt_q.op2)
		else report_mismatch("ex_pkt_o.op2", 64'($sampled(exp_pkt_q.op2)),
			64'($sampled(ex_pkt_o.op2)));

	a_imm: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ex_valid_o && exp_valid_q |-> ex_pkt_o.imm == exp_pkt_q.imm)
		else report_mismatch("ex_pkt_o.imm", 64'($sampled(exp_pkt_q.imm)),
			64'($sampled(ex_pkt_o.imm)));

	a_dest: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ex_valid_o && exp_valid_q |->
		{ex_pkt_o.we, ex_pkt_o.waddr} == {exp_pkt_q.we, exp_pkt_q.waddr})
		else report_mismatch("ex_pkt_o.we,waddr",
			64'({$sampled(exp_pkt_q.we), $sampled(exp_pkt_q.waddr)}),
			64'({$sampled(ex_pkt_o.we), $sampled(ex_pkt_o.waddr)}));

	a_outstanding: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		held <= `EX_CREDITS)
		else begin
			other_err++;
			$display("more packets outstanding in execute than it has credits for");
		end

	initial begin
		arst_n_i      = 1'b1;
		fetch_valid_i = 1'b0;
		fetch_pkt_i   = '0;
		ex_wr_i       = '0;
		mem_wr_i      = '0;
		wb_wr_i       = '0;
		ex_mem_req_i  = '0;
		ex_credit_i   = 1'b0;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end
		// async reset lands before the first edge and spans three of them
		#1 arst_n_i = 1'b0;
		repeat (3) @(posedge clk_i);
		#2 arst_n_i = 1'b1;
		while (issued_seen < NPKT && cycles < LIMIT) begin
			@(posedge clk_i);
			update_model();
			#2;
			drive_inputs();
			cycles++;
		end
		// the last issued packet is compared at the following edge
		@(posedge clk_i);
		#2;
		if (cycles >= LIMIT) begin
			other_err++;
			$display("timeout after %0d cycles, %0d of %0d packets issued",
				cycles, issued_seen, NPKT);
		end
		if (credits_back != issued_seen) begin
			other_err++;
			$display("fetch credits returned (%0d) differ from packets issued (%0d)",
				credits_back, issued_seen);
		end
		if (model_q.size() != 0) begin
			other_err++;
			$display("%0d sent packets were never issued", model_q.size());
		end
		$display("errors: %0d value mismatches, %0d other failures", val_err, other_err);
		if (val_err == 0 && other_err == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/inst_queue.sv
hdl/reg_file.sv
hdl/id_opcode_decode.sv
hdl/cpu_id.sv
hdl/id_issue_port.sv
hdl/id_stage_top.sv
verif/tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
